/* hdl/ram_params.svh */
`ifndef RAM_PARAMS_SVH
`define RAM_PARAMS_SVH

// --------------------
// SRAM and bus widths
// --------------------
`define RAM_ADRS_WIDTH 19		// 512K x 8 part
`define RAM_DQ_WIDTH 8
`define UFI_BUS_WIDTH 8			// Byte wide UFI slave
`define BUS_ADRS_BIT 32

// --------------------
// Queue and strobe timing
// --------------------
`define RAM_FIFO_DEPTH 8		// Command slots
`define RAM_STROBE_CYCLES 2		// Enables low this long per access

// Top address byte of this block on USI
`define RAM_BLOCK_MAP 8'h06

`endif

/* hdl/ramPkg.sv */
`include "ram_params.svh"

package ramPkg;

	// --------------------
	// UFI side
	// --------------------

	// Queued command, the FIFO payload
	typedef struct packed
	{
		logic							isRead;	// High read, low write
		logic [`RAM_ADRS_WIDTH-1:0]		adrs;	// SRAM byte address
		logic [`UFI_BUS_WIDTH-1:0]		wd;		// Write byte, unused on reads
	} ufiReqT;

	// Read return toward the master
	typedef struct packed
	{
		logic [`UFI_BUS_WIDTH-1:0]		rd;
		logic							rEd;	// One pulse per read
	} ufiRspT;

	// --------------------
	// SRAM pins
	// --------------------
	typedef struct packed
	{
		logic [`RAM_ADRS_WIDTH-1:0]		adrs;
		logic							oe;		// Active low
		logic							we;		// Active low
		logic							ce;		// Active low
	} memCtlT;

	// USI slave cycle
	typedef struct packed
	{
		logic [31:0]					wd;
		logic [`BUS_ADRS_BIT-1:0]		adrs;	// Top byte is the block map
		logic							wCke;	// High write, low read
	} usiReqT;

endpackage

/* hdl/ramCmdFifo.sv */
`timescale 1ns/10ps
`include "ram_params.svh"

module ramCmdFifo
(
	input	logic				sysClk,
	input	logic				reset,
	input	logic				push,
	input	ramPkg::ufiReqT		pushData,
	output	logic				full,
	input	logic				pop,
	output	ramPkg::ufiReqT		popData,	// Head entry, fall through
	output	logic				empty
);

	localparam int depth = `RAM_FIFO_DEPTH;
	localparam int ptrWidth = (depth > 1) ? $clog2(depth) : 1;
	localparam int cntWidth = $clog2(depth + 1);	// Must hold depth itself

	ramPkg::ufiReqT			mem [depth];
	logic [ptrWidth-1:0]	wrPtr;
	logic [ptrWidth-1:0]	rdPtr;
	logic [cntWidth-1:0]	count;
	logic					doPush;
	logic					doPop;

	// Guard against a stray strobe on a full or empty queue
	assign doPush = push && !full;
	assign doPop = pop && !empty;

	// --------------------
	// Storage
	// --------------------
	always_ff @(posedge sysClk)
	begin
		if (doPush)
			mem[wrPtr] <= pushData;
	end

	assign popData = mem[rdPtr];

	// --------------------
	// Pointers and occupancy
	// --------------------
	always_ff @(posedge sysClk)
	begin
		if (reset)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (doPush)
				wrPtr <= (wrPtr == ptrWidth'(depth - 1)) ? '0 : wrPtr + 1'b1;	// Wrap
			if (doPop)
				rdPtr <= (rdPtr == ptrWidth'(depth - 1)) ? '0 : rdPtr + 1'b1;
			case ({doPush, doPop})
				2'b10:		count <= count + 1'b1;
				2'b01:		count <= count - 1'b1;
				default:	count <= count;		// Both or neither
			endcase
		end
	end

	// Flags straight off the count, so full rises right after the filling push
	assign full = (count == cntWidth'(depth));
	assign empty = (count == '0);

endmodule

/* hdl/ramUnit.sv */
`timescale 1ns/10ps
`include "ram_params.svh"

module ramUnit
(
	input	logic							sysClk,
	input	logic							reset,
	// UFI slave
	input	logic [`UFI_BUS_WIDTH-1:0]		ufiWd,
	input	logic [`BUS_ADRS_BIT-1:0]		ufiAdrs,
	input	logic							ufiWEd,
	input	logic							ufiREd,
	output	logic							rdy,
	output	ramPkg::ufiRspT					ufiRsp,
	output	logic							writeDone,	// One pulse per write
	// SRAM pins
	output	ramPkg::memCtlT					memCtl,
	inout	wire [`RAM_DQ_WIDTH-1:0]		dq
);

	localparam int cntWidth = $clog2(`RAM_STROBE_CYCLES + 1);

	typedef enum logic [1:0]
	{
		stIdle,
		stSetup,	// Address out, enables high
		stStrobe,	// ce and oe or we low
		stRelease	// Enables back high, result out
	} seqStateT;

	ramPkg::ufiReqT			pushCmd;
	ramPkg::ufiReqT			headCmd;
	ramPkg::ufiReqT			cmd;		// Command in flight
	seqStateT				state;
	logic [cntWidth-1:0]	strobeCnt;
	logic					lastStrobe;
	logic					fifoPop;
	logic					fifoFull;
	logic					fifoEmpty;
	logic					driveDq;
	logic [`RAM_DQ_WIDTH-1:0]	rdByte;

	// --------------------
	// Command queue
	// --------------------
	always_comb
	begin
		pushCmd.isRead = ufiREd;
		pushCmd.adrs = ufiAdrs[`RAM_ADRS_WIDTH-1:0];	// Low bits pick the byte
		pushCmd.wd = ufiWd;
	end

	ramCmdFifo ramCmdFifo_i
	(
		.sysClk		(sysClk),
		.reset		(reset),
		.push		(ufiWEd || ufiREd),
		.pushData	(pushCmd),
		.full		(fifoFull),
		.pop		(fifoPop),
		.popData	(headCmd),
		.empty		(fifoEmpty)
	);

	assign rdy = !fifoFull;
	assign fifoPop = (state == stIdle) && !fifoEmpty;

	// --------------------
	// Sequencer
	// --------------------
	assign lastStrobe = (strobeCnt == cntWidth'(`RAM_STROBE_CYCLES - 1));

	always_ff @(posedge sysClk)
	begin
		if (reset)
		begin
			state <= stIdle;
			strobeCnt <= '0;
		end
		else
		begin
			case (state)
				stIdle:
				begin
					if (!fifoEmpty)
						state <= stSetup;
				end
				stSetup:
				begin
					strobeCnt <= '0;
					state <= stStrobe;
				end
				stStrobe:
				begin
					strobeCnt <= strobeCnt + 1'b1;
					if (lastStrobe)
						state <= stRelease;
				end
				default:
					state <= stIdle;	// Release lasts one cycle
			endcase
		end
	end

	// Payload capture
	always_ff @(posedge sysClk)
	begin
		if (fifoPop)
			cmd <= headCmd;
		if ((state == stStrobe) && lastStrobe && cmd.isRead)
			rdByte <= dq;		// Sample at end of the strobe
	end

	// --------------------
	// Pins and events
	// --------------------
	always_comb
	begin
		memCtl.adrs = cmd.adrs;
		memCtl.ce = (state != stStrobe);
		memCtl.oe = !((state == stStrobe) && cmd.isRead);
		memCtl.we = !((state == stStrobe) && !cmd.isRead);
	end

	// Write data covers setup and strobe only
	assign driveDq = ((state == stSetup) || (state == stStrobe)) && !cmd.isRead;
	assign dq = driveDq ? cmd.wd : 'z;

	assign ufiRsp.rd = rdByte;
	assign ufiRsp.rEd = (state == stRelease) && cmd.isRead;
	assign writeDone = (state == stRelease) && !cmd.isRead;

endmodule

/* hdl/ramCsr.sv */
`timescale 1ns/10ps
`include "ram_params.svh"

module ramCsr
(
	input	logic				sysClk,
	input	logic				reset,
	// USI slave
	input	ramPkg::usiReqT		usiReq,
	output	logic [31:0]		usiRd,
	output	logic				usiREd,
	// Events from the access unit
	input	ramPkg::ufiRspT		ufiRsp,
	input	logic				writeDone
);

	logic [`UFI_BUS_WIDTH-1:0]	lastRd;		// Reg 0
	logic [31:0]				readCount;	// Reg 1
	logic [31:0]				writeCount;	// Reg 2
	logic [31:0]				scratch;	// Reg 3
	logic						blockSel;
	logic [1:0]					regSel;
	logic [31:0]				regMux;

	// --------------------
	// Decode
	// --------------------
	assign blockSel = (usiReq.adrs[`BUS_ADRS_BIT-1 -: 8] == `RAM_BLOCK_MAP);
	assign regSel = usiReq.adrs[3:2];	// Word select

	always_comb
	begin
		case (regSel)
			2'd0:		regMux = 32'(lastRd);	// Zero extended
			2'd1:		regMux = readCount;
			2'd2:		regMux = writeCount;
			default:	regMux = scratch;
		endcase
	end

	// --------------------
	// Registers
	// --------------------
	always_ff @(posedge sysClk)
	begin
		if (reset)
		begin
			lastRd <= '0;
			readCount <= '0;
			writeCount <= '0;
			scratch <= '0;
		end
		else
		begin
			if (ufiRsp.rEd)
			begin
				lastRd <= ufiRsp.rd;
				readCount <= readCount + 1'b1;
			end
			if (writeDone)
				writeCount <= writeCount + 1'b1;
			// Only the scratch word takes USI writes
			if (blockSel && usiReq.wCke && (regSel == 2'd3))
				scratch <= usiReq.wd;
		end
	end

	// Read return one cycle after the request
	always_ff @(posedge sysClk)
	begin
		if (reset)
		begin
			usiRd <= '0;
			usiREd <= 1'b0;
		end
		else
		begin
			usiREd <= blockSel && !usiReq.wCke;
			if (blockSel && !usiReq.wCke)
				usiRd <= regMux;
		end
	end

endmodule

/* hdl/ramBlock.sv */
`timescale 1ns/10ps
`include "ram_params.svh"

module ramBlock
(
	input	logic							sysClk,
	input	logic							reset,
	// External SRAM
	output	ramPkg::memCtlT					memCtl,
	inout	wire [`RAM_DQ_WIDTH-1:0]		dq,
	// USI slave
	input	ramPkg::usiReqT					usiReq,
	output	logic [31:0]					usiRd,
	output	logic							usiREd,
	// UFI slave
	input	logic [`UFI_BUS_WIDTH-1:0]		ufiWd,
	input	logic [`BUS_ADRS_BIT-1:0]		ufiAdrs,
	input	logic							ufiWEd,
	input	logic							ufiREd,
	output	ramPkg::ufiRspT					ufiRsp,
	output	logic							rdy
);

	logic	writeDone;	// Write completion, unit to CSR

	// --------------------
	// Access unit
	// --------------------
	ramUnit ramUnit_i
	(
		.sysClk		(sysClk),
		.reset		(reset),
		.ufiWd		(ufiWd),
		.ufiAdrs	(ufiAdrs),
		.ufiWEd		(ufiWEd),
		.ufiREd		(ufiREd),
		.rdy		(rdy),
		.ufiRsp		(ufiRsp),
		.writeDone	(writeDone),
		.memCtl		(memCtl),
		.dq			(dq)
	);

	// --------------------
	// CSR space
	// --------------------
	ramCsr ramCsr_i
	(
		.sysClk		(sysClk),
		.reset		(reset),
		.usiReq		(usiReq),
		.usiRd		(usiRd),
		.usiREd		(usiREd),
		.ufiRsp		(ufiRsp),	// Read return also feeds reg 0 and the count
		.writeDone	(writeDone)
	);

endmodule

/* bench/sramModel.sv */
`timescale 1ns/10ps
`include "ram_params.svh"

module sramModel
(
	input	ramPkg::memCtlT					memCtl,
	inout	wire [`RAM_DQ_WIDTH-1:0]		dq
);

	logic [`RAM_DQ_WIDTH-1:0]	cells [int];	// Sparse, written bytes only
	logic [`RAM_DQ_WIDTH-1:0]	rdData;
	logic						outEn;

	// Untouched bytes read a pattern spread over the whole address
	function automatic logic [7:0] fillByte(input logic [`RAM_ADRS_WIDTH-1:0] a);
		return a[7:0] ^ a[15:8] ^ {5'b0, a[18:16]} ^ 8'h5a;
	endfunction

	// Level write while ce and we are low, skip the instant the bus floats
	always @(memCtl or dq)
	begin
		if (!memCtl.ce && !memCtl.we && !$isunknown(dq))
			cells[memCtl.adrs] = dq;
	end

	always @(memCtl)
	begin
		rdData = cells.exists(memCtl.adrs) ? cells[memCtl.adrs] : fillByte(memCtl.adrs);
	end

	assign outEn = !memCtl.ce && !memCtl.oe && memCtl.we;
	assign dq = outEn ? rdData : 'z;

endmodule

/* bench/ramBlockChecker.sv */
`timescale 1ns/10ps
`include "ram_params.svh"

module ramBlockChecker
(
	input	logic							sysClk,
	input	logic							reset,
	input	ramPkg::memCtlT					memCtl,
	input	ramPkg::usiReqT					usiReq,
	input	logic [31:0]					usiRd,
	input	logic							usiREd,
	input	logic [`UFI_BUS_WIDTH-1:0]		ufiWd,
	input	logic [`BUS_ADRS_BIT-1:0]		ufiAdrs,
	input	logic							ufiWEd,
	input	logic							ufiREd,
	input	ramPkg::ufiRspT					ufiRsp,
	input	logic							rdy,
	input	logic [1:0]						phase,		// Names the running test
	output	int								errorCount,
	output	int								outstanding	// Accepted, not yet done
);

	logic [7:0]		refMem [512];	// Bench stays below 512
	logic [7:0]		expReads [$];	// Read bytes in command order
	logic [8:0]		expAdrs [$];	// SRAM addresses in command order
	int				checkCount = 0;
	int				valueErrors = 0;
	int				protocolErrors = 0;
	int				accepted = 0;
	int				readsDone = 0;
	int				writesDone = 0;
	logic [7:0]		lastRead = '0;
	logic [31:0]	scratch = '0;
	logic			usiPending = 1'b0;	// Mapped read seen last edge
	logic [31:0]	usiExpected = '0;
	logic [1:0]		usiReg = '0;
	logic			prevWe = 1'b1;
	logic			prevCe = 1'b1;
	logic			prevReset = 1'b0;

	assign errorCount = valueErrors + protocolErrors;
	assign outstanding = accepted - readsDone - writesDone;

	function automatic string testName(input logic [1:0] p);
		case (p)
			2'd1:		return "writeReadBack";
			2'd2:		return "randomTraffic";
			default:	return "csrAccess";
		endcase
	endfunction

	function automatic string csrName(input logic [1:0] r);
		case (r)
			2'd0:		return "csrLastRead";
			2'd1:		return "csrReadCount";
			2'd2:		return "csrWriteCount";
			default:	return "csrScratch";
		endcase
	endfunction

	task automatic compareValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checkCount++;
		if (expected !== actual)
		begin
			valueErrors++;
			$display("FAILED %s: expected %h, actual %h at %0t", name, expected, actual, $time);
		end
	endtask

	task automatic flagProtocol(input string what);
		protocolErrors++;
		$display("ERROR: %s at %0t", what, $time);
	endtask

	task automatic printCounts();
		$display("Checks %0d, value errors %0d, protocol errors %0d, reads %0d, writes %0d",
			checkCount, valueErrors, protocolErrors, readsDone, writesDone);
	endtask

	// --------------------
	// Per-cycle checks
	// --------------------
	task automatic checkResetState();
		compareValue("resetEnables", 32'b111, {memCtl.oe, memCtl.we, memCtl.ce});
		compareValue("resetRdy", 32'b1, rdy);
		if (ufiRsp.rEd)
			flagProtocol("read return pulsed during reset");
		if (usiREd)
			flagProtocol("usiREd pulsed during reset");
	endtask

	task automatic checkUsi();
		if (usiPending && !usiREd)
			flagProtocol("mapped USI read got no usiREd one cycle later");
		else if (!usiPending && usiREd)
			flagProtocol("usiREd pulsed without a mapped read");
		else if (usiPending)
			compareValue(csrName(usiReg), usiExpected, usiRd);
		// Sample before this edge's events, as the CSR mux does
		usiPending = (usiReq.adrs[31:24] == `RAM_BLOCK_MAP) && !usiReq.wCke;
		usiReg = usiReq.adrs[3:2];
		case (usiReg)
			2'd0:		usiExpected = {24'h0, lastRead};
			2'd1:		usiExpected = readsDone;
			2'd2:		usiExpected = writesDone;
			default:	usiExpected = scratch;
		endcase
		if ((usiReq.adrs[31:24] == `RAM_BLOCK_MAP) && usiReq.wCke && (usiReg == 2'd3))
			scratch = usiReq.wd;
	endtask

	task automatic checkUfi();
		logic [7:0] expected;
		logic [8:0] nextAdrs;
		if (!memCtl.ce && !memCtl.we && !memCtl.oe)
			flagProtocol("SRAM oe and we both low in one cycle");
		// First strobe cycle of an access carries that command's address
		if (prevCe && !memCtl.ce)
		begin
			if (expAdrs.size() == 0)
				flagProtocol("SRAM cycle started with no command queued");
			else
			begin
				nextAdrs = expAdrs.pop_front();
				compareValue("sramAddress", 32'(nextAdrs), 32'(memCtl.adrs));
			end
		end
		prevCe = memCtl.ce;
		if (!prevWe && memCtl.we)
			writesDone++;		// Write strobe just ended
		prevWe = memCtl.we;
		if (ufiRsp.rEd)
		begin
			readsDone++;
			if (expReads.size() == 0)
				flagProtocol("read return with no read outstanding");
			else
			begin
				expected = expReads.pop_front();
				compareValue(testName(phase), expected, ufiRsp.rd);
				lastRead = expected;
			end
		end
		if ((ufiWEd || ufiREd) && !rdy)
			flagProtocol("master strobed while rdy was low");
		else if (ufiWEd)
		begin
			refMem[ufiAdrs[8:0]] = ufiWd;
			expAdrs.push_back(ufiAdrs[8:0]);
			accepted++;
		end
		else if (ufiREd)
		begin
			expReads.push_back(refMem[ufiAdrs[8:0]]);
			expAdrs.push_back(ufiAdrs[8:0]);
			accepted++;
		end
	endtask

	always @(posedge sysClk)
	begin
		if (prevReset)
			checkResetState();	// Held and first cycle after
		if (!reset)
		begin
			checkUsi();
			checkUfi();
		end
		prevReset = reset;
	end

endmodule

/* bench/ramBlockTb.sv */
`timescale 1ns/10ps
`include "ram_params.svh"

module ramBlockTb;

	localparam int randomOps = 300;
	localparam int timeoutCycles = 400 * (`RAM_STROBE_CYCLES + 4) + 200;

	logic							sysClk;
	logic							reset;
	ramPkg::memCtlT					memCtl;
	wire [`RAM_DQ_WIDTH-1:0]		dq;
	ramPkg::usiReqT					usiReq;
	logic [31:0]					usiRd;
	logic							usiREd;
	logic [`UFI_BUS_WIDTH-1:0]		ufiWd;
	logic [`BUS_ADRS_BIT-1:0]		ufiAdrs;
	logic							ufiWEd;
	logic							ufiREd;
	ramPkg::ufiRspT					ufiRsp;
	logic							rdy;
	logic [1:0]						phase;
	int								errorCount;
	int								outstanding;
	int								cycleCount = 0;
	integer							seed = 32'h68e8_0d46;
	bit								written [512];	// Safe to read back

	always #50 sysClk = !sysClk;

	ramBlock ramBlock_i
	(
		.sysClk		(sysClk),
		.reset		(reset),
		.memCtl		(memCtl),
		.dq			(dq),
		.usiReq		(usiReq),
		.usiRd		(usiRd),
		.usiREd		(usiREd),
		.ufiWd		(ufiWd),
		.ufiAdrs	(ufiAdrs),
		.ufiWEd		(ufiWEd),
		.ufiREd		(ufiREd),
		.ufiRsp		(ufiRsp),
		.rdy		(rdy)
	);

	sramModel sramModel_i (.memCtl(memCtl), .dq(dq));

	ramBlockChecker ramBlockChecker_i
	(
		.sysClk(sysClk), .reset(reset), .memCtl(memCtl), .usiReq(usiReq),
		.usiRd(usiRd), .usiREd(usiREd), .ufiWd(ufiWd), .ufiAdrs(ufiAdrs),
		.ufiWEd(ufiWEd), .ufiREd(ufiREd), .ufiRsp(ufiRsp), .rdy(rdy),
		.phase(phase), .errorCount(errorCount), .outstanding(outstanding)
	);

	task automatic stepCycle();
		@(posedge sysClk);
		#5;			// Inputs change clear of the edge
	endtask

	// One UFI command, held off while the queue is full
	task automatic sendCommand(input bit isRead, input logic [8:0] adrs, input logic [7:0] wd);
		while (!rdy)
			stepCycle();
		ufiREd = isRead;
		ufiWEd = !isRead;
		ufiAdrs = {23'h0, adrs};
		ufiWd = wd;
		stepCycle();
		ufiREd = 1'b0;
		ufiWEd = 1'b0;
		if (!isRead)
			written[adrs] = 1'b1;
	endtask

	task automatic usiAccess(input bit wCke, input logic [7:0] map, input logic [1:0] regNum,
		input logic [31:0] wd);
		usiReq.wCke = wCke;
		usiReq.adrs = {map, 20'h0, regNum, 2'b00};
		usiReq.wd = wd;
		stepCycle();
		usiReq = '0;	// Top byte zero, not this block
	endtask

	task automatic drain();
		while (outstanding != 0)
			stepCycle();
	endtask

	// Run limit from the command budget
	always @(posedge sysClk)
	begin
		cycleCount++;
		if (cycleCount > timeoutCycles)
		begin
			$display("Timeout: run still busy after %0d cycles", timeoutCycles);
			ramBlockChecker_i.printCounts();
			$display("Simulation FAILED");
			$finish;
		end
	end

	initial
	begin
		logic [8:0] adrs;
		logic [7:0] otherMap;
		bit doRead;
		sysClk = 1'b0;
		reset = 1'b1;
		usiReq = '0;
		ufiWd = '0;
		ufiAdrs = '0;
		ufiWEd = 1'b0;
		ufiREd = 1'b0;
		phase = 2'd0;
		repeat (10) @(posedge sysClk);
		#5;
		reset = 1'b0;
		repeat (3) stepCycle();

		// -------------------- Write then read back
		phase = 2'd1;
		for (int i = 0; i < 8; i++)
			sendCommand(1'b0, 9'(i * 67), 8'($random(seed)));
		for (int i = 0; i < 8; i++)
			sendCommand(1'b1, 9'(i * 67), 8'h00);
		drain();

		// -------------------- Random traffic, queue runs full
		phase = 2'd2;
		for (int i = 0; i < randomOps; i++)
		begin
			adrs = 9'($random(seed));
			doRead = (($random(seed) % 2) != 0) && written[adrs];	// Unwritten turn into writes
			if (({$random(seed)} % 8) == 0)
			begin
				usiReq.wCke = 1'b0;
				usiReq.adrs = {`RAM_BLOCK_MAP, 20'h0, 2'({$random(seed)} % 3), 2'b00};
			end
			else
				usiReq = '0;
			if (({$random(seed)} % 4) == 0)
				stepCycle();	// Occasional gap
			sendCommand(doRead, adrs, 8'($random(seed)));
		end
		usiReq = '0;
		drain();

		// -------------------- CSRs and address map
		phase = 2'd3;
		for (int r = 0; r < 4; r++)
			usiAccess(1'b0, `RAM_BLOCK_MAP, 2'(r), 32'h0);
		usiAccess(1'b1, `RAM_BLOCK_MAP, 2'd3, $random(seed));
		usiAccess(1'b0, `RAM_BLOCK_MAP, 2'd3, 32'h0);
		usiAccess(1'b1, `RAM_BLOCK_MAP, 2'd0, $random(seed));	// Read-only word
		otherMap = 8'($random(seed));
		if (otherMap == `RAM_BLOCK_MAP)
			otherMap = ~otherMap;
		usiAccess(1'b1, otherMap, 2'd3, $random(seed));
		usiAccess(1'b0, otherMap, 2'd3, 32'h0);
		for (int r = 0; r < 4; r++)
			usiAccess(1'b0, `RAM_BLOCK_MAP, 2'(r), 32'h0);
		repeat (2) stepCycle();

		ramBlockChecker_i.printCounts();
		if (errorCount == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

/* verilog.f */
+incdir+hdl
hdl/ramPkg.sv
hdl/ramCmdFifo.sv
hdl/ramUnit.sv
hdl/ramCsr.sv
hdl/ramBlock.sv
bench/sramModel.sv
bench/ramBlockChecker.sv
bench/ramBlockTb.sv

/* Bender.yml */
package:
  name: ram_block

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/ramPkg.sv
      - hdl/ramCmdFifo.sv
      - hdl/ramUnit.sv
      - hdl/ramCsr.sv
      - hdl/ramBlock.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - bench/sramModel.sv
      - bench/ramBlockChecker.sv
      - bench/ramBlockTb.sv
